//--- hdl/oflow_defs.svh
// shared widths and depths of the object-tracking conflict stage
//   score board geometry (rows, PEs per row)
//   score and object ID widths
//   ID table address and slot widths
//   histogram depth and occurrence counter width
//   default abort threshold for repeated IDs

`ifndef OFLOW_DEFS_SVH
`define OFLOW_DEFS_SVH

// score board geometry
`define OFLOW_ROWS        4
`define OFLOW_PES         4

// entry payload widths
`define OFLOW_SCORE_LEN   8
`define OFLOW_ID_LEN      7

// id table, 64 words, top id bit picks the half
`define OFLOW_LUT_ADDR_W  6
`define OFLOW_SLOT_LEN    5

// one histogram slot per board entry
`define OFLOW_MAX_SLOTS   16
`define OFLOW_INST_LEN    4

// abort once an id has been seen this many times
`define OFLOW_CONFLICT_TH 4

`endif

//--- hdl/oflow_pkg.sv
// types of the conflict-resolution stage
//   score, object id, row and PE index
//   histogram slot and two-slot id table word
//   resolver scan states

`default_nettype none

`include "oflow_defs.svh"

package oflow_pkg;

	typedef logic [`OFLOW_SCORE_LEN-1:0] score_t;

	// zero id marks an empty entry
	typedef logic [`OFLOW_ID_LEN-1:0] id_t;

	typedef logic [$clog2(`OFLOW_ROWS)-1:0] row_t;
	typedef logic [$clog2(`OFLOW_PES)-1:0] pe_t;

	// slot number stored as index plus one, zero is none
	typedef logic [`OFLOW_SLOT_LEN-1:0] slot_t;

	// half 1 holds ids with the top bit set
	typedef slot_t [1:0] lut_word_t;

	typedef enum logic [1:0] {
		idle_st,
		row_sel_st,
		pe_sel_fill_lut_st,
		fill_hist_st
	} cr_state_t;

endpackage

`default_nettype wire

//--- hdl/oflow_score_board.sv
// score board of the conflict stage
//   flop arrays of score, object id and fallback bit per entry
//   load port from the matcher, scan read port for the resolver
//   fallback set port and combinational readback port
//   checks on loads against the resolver

`default_nettype none

`include "oflow_defs.svh"

module oflow_score_board (
	input  logic              clk,
	input  logic              reset_N,

	// frame load from outside
	input  logic              load_en,
	input  oflow_pkg::row_t   load_row,
	input  oflow_pkg::pe_t    load_pe,
	input  oflow_pkg::score_t load_score,
	input  oflow_pkg::id_t    load_id,

	// scan read by the resolver
	input  oflow_pkg::row_t   row_sel,
	input  oflow_pkg::pe_t    pe_sel,
	output oflow_pkg::score_t score,
	output oflow_pkg::id_t    id,

	// fallback set by the resolver
	input  logic              fb_we,
	input  oflow_pkg::row_t   fb_row,
	input  oflow_pkg::pe_t    fb_pe,

	// readback while idle
	input  oflow_pkg::row_t   rd_row,
	input  oflow_pkg::pe_t    rd_pe,
	output logic              rd_fallback,

	input  logic              busy
);

	// ------------------------------------------------------------------------
	// entry storage
	// ------------------------------------------------------------------------
	oflow_pkg::score_t score_q    [`OFLOW_ROWS][`OFLOW_PES];
	oflow_pkg::id_t    id_q       [`OFLOW_ROWS][`OFLOW_PES];
	logic              fallback_q [`OFLOW_ROWS][`OFLOW_PES];

	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			for (int r = 0; r < `OFLOW_ROWS; r++) begin
				for (int p = 0; p < `OFLOW_PES; p++) begin
					score_q[r][p]    <= '0;
					id_q[r][p]       <= '0;
					fallback_q[r][p] <= 1'b0;
				end
			end
		end else begin
			// new match, previous fallback decision no longer holds
			if (load_en) begin
				score_q[load_row][load_pe]    <= load_score;
				id_q[load_row][load_pe]       <= load_id;
				fallback_q[load_row][load_pe] <= 1'b0;
			end
			// entry lost its match to a lower score
			if (fb_we) begin
				fallback_q[fb_row][fb_pe] <= 1'b1;
			end
		end
	end

	// ------------------------------------------------------------------------
	// read ports
	// ------------------------------------------------------------------------
	// resolver sees the entry in the select cycle
	assign score = score_q[row_sel][pe_sel];
	assign id    = id_q[row_sel][pe_sel];

	assign rd_fallback = fallback_q[rd_row][rd_pe];

	// ------------------------------------------------------------------------
	// checks
	// ------------------------------------------------------------------------
	// board belongs to the resolver during a scan
	a_no_load_busy: assert property (
		@(posedge clk) disable iff (!reset_N)
		load_en |-> !busy
	) else $error("score board loaded during a scan");

	// load and fallback set must not hit one entry together
	a_no_load_fb_clash: assert property (
		@(posedge clk) disable iff (!reset_N)
		(load_en && fb_we) |-> !(load_row == fb_row && load_pe == fb_pe)
	) else $error("load and fallback write to the same entry");

endmodule

`default_nettype wire

//--- hdl/oflow_id_lut.sv
// id to histogram slot table
//   64 words of two slots, half chosen by the top id bit
//   two seen flags per word, set by a word write
//   flags cleared together at scan start

`default_nettype none

`include "oflow_defs.svh"

module oflow_id_lut (
	input  logic                         clk,
	input  logic                         reset_N,

	// word port
	input  logic [`OFLOW_LUT_ADDR_W-1:0] lut_addr,
	output oflow_pkg::lut_word_t         lut_rdata,
	input  oflow_pkg::lut_word_t         lut_wdata,
	input  logic                         lut_we,

	// seen flags
	input  logic                         flag_half,
	output logic                         flag_seen,
	input  logic                         flag_clear
);

	localparam int lut_depth = 1 << `OFLOW_LUT_ADDR_W;

	// ------------------------------------------------------------------------
	// slot words
	// ------------------------------------------------------------------------
	oflow_pkg::lut_word_t lut_mem [lut_depth];

	always_ff @(posedge clk) begin
		if (lut_we) begin
			lut_mem[lut_addr] <= lut_wdata;
		end
	end

	// read is combinational, resolver merges in the same cycle
	assign lut_rdata = lut_mem[lut_addr];

	// ------------------------------------------------------------------------
	// seen flags, one per half
	// ------------------------------------------------------------------------
	// a half holds a valid slot only while its flag is set
	logic [lut_depth-1:0][1:0] seen_q;

	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			seen_q <= '0;
		end else if (flag_clear) begin
			seen_q <= '0;
		end else if (lut_we) begin
			seen_q[lut_addr][flag_half] <= 1'b1;
		end
	end

	assign flag_seen = seen_q[lut_addr][flag_half];

	// clear comes only in the start cycle, before any table write
	a_no_clear_on_write: assert property (
		@(posedge clk) disable iff (!reset_N)
		flag_clear |-> !lut_we
	) else $error("seen flags cleared during a table write");

endmodule

`default_nettype wire

//--- hdl/oflow_conflict_resolve_fsm.sv
// conflict resolver of the object-tracking stage
//   scan FSM over rows and PEs of the score board
//   id table lookup and new slot assignment
//   per slot histogram of count, lowest score and holder position
//   fallback decision and repeat threshold abort
// parameter max_conflicts: earlier occurrences that abort the scan

`default_nettype none

`include "oflow_defs.svh"

module oflow_conflict_resolve_fsm #(
	parameter int max_conflicts = `OFLOW_CONFLICT_TH
) (
	input  logic                         clk,
	input  logic                         reset_N,

	input  logic                         start,
	output logic                         done,
	output logic                         busy,
	output logic                         conflict_th,

	// score board scan
	output oflow_pkg::row_t              row_sel,
	output oflow_pkg::pe_t               pe_sel,
	input  oflow_pkg::score_t            score,
	input  oflow_pkg::id_t               id,

	// score board fallback set
	output logic                         fb_we,
	output oflow_pkg::row_t              fb_row,
	output oflow_pkg::pe_t               fb_pe,

	// id table
	output logic [`OFLOW_LUT_ADDR_W-1:0] lut_addr,
	output oflow_pkg::lut_word_t         lut_wdata,
	output logic                         lut_we,
	input  oflow_pkg::lut_word_t         lut_rdata,
	output logic                         flag_half,
	input  logic                         flag_seen,
	output logic                         flag_clear
);

	localparam int hist_w = $clog2(`OFLOW_MAX_SLOTS);

	typedef logic [`OFLOW_INST_LEN-1:0] inst_t;

	localparam inst_t conflict_lim = inst_t'(max_conflicts);

	// ------------------------------------------------------------------------
	// scan state
	// ------------------------------------------------------------------------
	oflow_pkg::cr_state_t state_q;
	oflow_pkg::cr_state_t state_nxt;

	oflow_pkg::row_t      row_cnt;
	oflow_pkg::pe_t       pe_cnt;
	logic                 pe_phase;
	// distinct ids seen so far this scan
	oflow_pkg::slot_t     slot_cnt;
	oflow_pkg::slot_t     cur_slot;
	logic                 done_q;
	logic                 conflict_q;

	// histogram, indexed by slot minus one
	inst_t                occ_q      [`OFLOW_MAX_SLOTS];
	oflow_pkg::score_t    min_q      [`OFLOW_MAX_SLOTS];
	oflow_pkg::row_t      hrow_q     [`OFLOW_MAX_SLOTS];
	oflow_pkg::pe_t       hpe_q      [`OFLOW_MAX_SLOTS];

	oflow_pkg::slot_t     new_slot;
	oflow_pkg::slot_t     slot_m1;
	logic [hist_w-1:0]    hist_idx;
	inst_t                occ_cur;
	logic                 last_pe;
	logic                 last_row;
	logic                 take_holder;
	logic                 abort;
	logic                 scan_end;

	assign row_sel  = row_cnt;
	assign pe_sel   = pe_cnt;
	assign busy     = (state_q != oflow_pkg::idle_st);
	assign done     = done_q;
	assign conflict_th = conflict_q;

	// tables get cleared in the cycle that accepts start
	assign flag_clear = (state_q == oflow_pkg::idle_st) && start;

	// ------------------------------------------------------------------------
	// id table addressing
	// ------------------------------------------------------------------------
	// low id bits pick the word, top bit the half
	assign lut_addr  = id[`OFLOW_LUT_ADDR_W-1:0];
	assign flag_half = id[`OFLOW_ID_LEN-1];
	assign new_slot  = slot_cnt + oflow_pkg::slot_t'(1);

	// keep the other half, drop the new slot into ours
	always_comb begin
		lut_wdata            = lut_rdata;
		lut_wdata[flag_half] = new_slot;
	end

	// unseen id gets its word on the second select cycle
	assign lut_we = (state_q == oflow_pkg::pe_sel_fill_lut_st) && pe_phase && !flag_seen;

	// histogram entry of the current id
	assign slot_m1  = cur_slot - oflow_pkg::slot_t'(1);
	assign hist_idx = slot_m1[hist_w-1:0];
	assign occ_cur  = occ_q[hist_idx];

	assign last_pe  = (pe_cnt == oflow_pkg::pe_t'(`OFLOW_PES - 1));
	assign last_row = (row_cnt == oflow_pkg::row_t'(`OFLOW_ROWS - 1));

	// count before the update decides the abort
	assign abort = (state_q == oflow_pkg::fill_hist_st) && (occ_cur >= conflict_lim);

	// ------------------------------------------------------------------------
	// resolution rule
	// ------------------------------------------------------------------------
	always_comb begin
		take_holder = 1'b0;
		fb_we       = 1'b0;
		fb_row      = row_cnt;
		fb_pe       = pe_cnt;
		if (state_q == oflow_pkg::fill_hist_st) begin
			if (occ_cur == '0) begin
				// first occurrence holds the match
				take_holder = 1'b1;
			end else if (score < min_q[hist_idx]) begin
				// strictly lower, old holder falls back
				take_holder = 1'b1;
				fb_we       = 1'b1;
				fb_row      = hrow_q[hist_idx];
				fb_pe       = hpe_q[hist_idx];
			end else begin
				// tie or higher, this entry falls back
				fb_we = 1'b1;
			end
		end
	end

	// ------------------------------------------------------------------------
	// next state
	// ------------------------------------------------------------------------
	always_comb begin
		state_nxt = state_q;
		scan_end  = 1'b0;
		case (state_q)
			oflow_pkg::idle_st: begin
				if (start) begin
					state_nxt = oflow_pkg::row_sel_st;
				end
			end
			oflow_pkg::row_sel_st: begin
				state_nxt = oflow_pkg::pe_sel_fill_lut_st;
			end
			oflow_pkg::pe_sel_fill_lut_st: begin
				if (!pe_phase && id == '0) begin
					// empty entry ends the frame
					state_nxt = oflow_pkg::idle_st;
					scan_end  = 1'b1;
				end else if (pe_phase) begin
					state_nxt = oflow_pkg::fill_hist_st;
				end
			end
			oflow_pkg::fill_hist_st: begin
				if (abort || (last_pe && last_row)) begin
					state_nxt = oflow_pkg::idle_st;
					scan_end  = 1'b1;
				end else if (last_pe) begin
					state_nxt = oflow_pkg::row_sel_st;
				end else begin
					state_nxt = oflow_pkg::pe_sel_fill_lut_st;
				end
			end
			default: begin
				state_nxt = oflow_pkg::idle_st;
			end
		endcase
	end

	// ------------------------------------------------------------------------
	// control registers
	// ------------------------------------------------------------------------
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			state_q    <= oflow_pkg::idle_st;
			row_cnt    <= '0;
			pe_cnt     <= '0;
			pe_phase   <= 1'b0;
			slot_cnt   <= '0;
			cur_slot   <= '0;
			done_q     <= 1'b0;
			conflict_q <= 1'b0;
		end else begin
			state_q  <= state_nxt;
			// done one cycle after the last write lands
			done_q   <= scan_end;
			pe_phase <= (state_q == oflow_pkg::pe_sel_fill_lut_st) && !pe_phase;
			if (flag_clear) begin
				row_cnt    <= '0;
				slot_cnt   <= '0;
				conflict_q <= 1'b0;
			end
			if (state_q == oflow_pkg::row_sel_st) begin
				pe_cnt <= '0;
			end
			// slot known on the second select cycle
			if (state_q == oflow_pkg::pe_sel_fill_lut_st && pe_phase) begin
				cur_slot <= flag_seen ? lut_rdata[flag_half] : new_slot;
				if (!flag_seen) begin
					slot_cnt <= new_slot;
				end
			end
			if (state_q == oflow_pkg::fill_hist_st) begin
				if (abort) begin
					conflict_q <= 1'b1;
				end else if (last_pe) begin
					row_cnt <= row_cnt + oflow_pkg::row_t'(1);
				end else begin
					pe_cnt <= pe_cnt + oflow_pkg::pe_t'(1);
				end
			end
		end
	end

	// ------------------------------------------------------------------------
	// histogram
	// ------------------------------------------------------------------------
	// counts restart every scan
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			for (int s = 0; s < `OFLOW_MAX_SLOTS; s++) begin
				occ_q[s] <= '0;
			end
		end else if (flag_clear) begin
			for (int s = 0; s < `OFLOW_MAX_SLOTS; s++) begin
				occ_q[s] <= '0;
			end
		end else if (state_q == oflow_pkg::fill_hist_st) begin
			occ_q[hist_idx] <= occ_cur + inst_t'(1);
		end
	end

	// holder fields written on first occurrence before any read
	always_ff @(posedge clk) begin
		if (take_holder) begin
			min_q[hist_idx]  <= score;
			hrow_q[hist_idx] <= row_cnt;
			hpe_q[hist_idx]  <= pe_cnt;
		end
	end

	// table word and flags must hand fill a real slot
	a_fill_slot_valid: assert property (
		@(posedge clk) disable iff (!reset_N)
		(state_q == oflow_pkg::fill_hist_st) |-> (cur_slot != '0)
	) else $error("histogram fill with empty slot");

endmodule

`default_nettype wire

//--- hdl/oflow_conflict_top.sv
// conflict-resolution subsystem top
//   score board, id table and resolver side by side
//   parameter max_conflicts passed to the resolver

`default_nettype none

`include "oflow_defs.svh"

module oflow_conflict_top #(
	parameter int max_conflicts = `OFLOW_CONFLICT_TH
) (
	input  logic              clk,
	input  logic              reset_N,

	input  logic              start,
	output logic              done,
	output logic              busy,
	output logic              conflict_th,

	input  logic              load_en,
	input  oflow_pkg::row_t   load_row,
	input  oflow_pkg::pe_t    load_pe,
	input  oflow_pkg::score_t load_score,
	input  oflow_pkg::id_t    load_id,

	input  oflow_pkg::row_t   rd_row,
	input  oflow_pkg::pe_t    rd_pe,
	output logic              rd_fallback
);

	// ------------------------------------------------------------------------
	// internal nets
	// ------------------------------------------------------------------------
	// board scan and fallback path
	oflow_pkg::row_t              row_sel;
	oflow_pkg::pe_t               pe_sel;
	oflow_pkg::score_t            score;
	oflow_pkg::id_t               id;
	logic                         fb_we;
	oflow_pkg::row_t              fb_row;
	oflow_pkg::pe_t               fb_pe;

	// id table path
	logic [`OFLOW_LUT_ADDR_W-1:0] lut_addr;
	oflow_pkg::lut_word_t         lut_wdata;
	oflow_pkg::lut_word_t         lut_rdata;
	logic                         lut_we;
	logic                         flag_half;
	logic                         flag_seen;
	logic                         flag_clear;

	oflow_score_board u_score_board (
		.clk         (clk),
		.reset_N     (reset_N),
		.load_en     (load_en),
		.load_row    (load_row),
		.load_pe     (load_pe),
		.load_score  (load_score),
		.load_id     (load_id),
		.row_sel     (row_sel),
		.pe_sel      (pe_sel),
		.score       (score),
		.id          (id),
		.fb_we       (fb_we),
		.fb_row      (fb_row),
		.fb_pe       (fb_pe),
		.rd_row      (rd_row),
		.rd_pe       (rd_pe),
		.rd_fallback (rd_fallback),
		.busy        (busy)
	);

	oflow_id_lut u_id_lut (
		.clk        (clk),
		.reset_N    (reset_N),
		.lut_addr   (lut_addr),
		.lut_rdata  (lut_rdata),
		.lut_wdata  (lut_wdata),
		.lut_we     (lut_we),
		.flag_half  (flag_half),
		.flag_seen  (flag_seen),
		.flag_clear (flag_clear)
	);

	oflow_conflict_resolve_fsm #(
		.max_conflicts (max_conflicts)
	) u_resolve_fsm (
		.clk         (clk),
		.reset_N     (reset_N),
		.start       (start),
		.done        (done),
		.busy        (busy),
		.conflict_th (conflict_th),
		.row_sel     (row_sel),
		.pe_sel      (pe_sel),
		.score       (score),
		.id          (id),
		.fb_we       (fb_we),
		.fb_row      (fb_row),
		.fb_pe       (fb_pe),
		.lut_addr    (lut_addr),
		.lut_wdata   (lut_wdata),
		.lut_we      (lut_we),
		.lut_rdata   (lut_rdata),
		.flag_half   (flag_half),
		.flag_seen   (flag_seen),
		.flag_clear  (flag_clear)
	);

endmodule

`default_nettype wire

//--- tb/oflow_clk_gen.sv
// testbench clock and reset source
//   free running clock, 4 ns period
//   active low reset held for a number of cycles, released on a falling edge

`default_nettype none

module oflow_clk_gen #(
	parameter int reset_cycles = 5
) (
	output logic clk,
	output logic reset_N
);

	timeunit 1ns;
	timeprecision 100ps;

	// half of the 4 ns period
	localparam int half_period = 2;

	initial begin
		clk = 1'b0;
		forever #half_period clk = ~clk;
	end

	// release away from the rising edge
	initial begin
		reset_N = 1'b0;
		repeat (reset_cycles) @(posedge clk);
		@(negedge clk);
		reset_N = 1'b1;
	end

endmodule

`default_nettype wire

//--- tb/oflow_conflict_tb.sv
// testbench of the conflict-resolution subsystem
//   LFSR stimulus and random frames from a small id pool
//   reference model of the resolution rule in scan order
//   compare tasks for fallback bits, conflict flag and handshake
//   cycle watchdog and final verdict

`default_nettype none

`include "oflow_defs.svh"

module oflow_conflict_tb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int n_entries      = `OFLOW_ROWS * `OFLOW_PES;
	localparam int max_conflicts  = 4;
	localparam int n_random       = 40;
	localparam int n_zero         = 8;
	localparam int n_conflict     = 6;
	localparam int n_frames       = 1 + n_random + n_zero + n_conflict;
	// loads, scan and readback fit well inside 200 cycles
	localparam int timeout_cycles = 200 * n_frames + 100;

	logic              clk;
	logic              reset_N;
	logic              start;
	logic              done;
	logic              busy;
	logic              conflict_th;
	logic              load_en;
	oflow_pkg::row_t   load_row;
	oflow_pkg::pe_t    load_pe;
	oflow_pkg::score_t load_score;
	oflow_pkg::id_t    load_id;
	oflow_pkg::row_t   rd_row;
	oflow_pkg::pe_t    rd_pe;
	logic              rd_fallback;

	// current frame and its expected outcome
	oflow_pkg::score_t f_score [n_entries];
	oflow_pkg::id_t    f_id    [n_entries];
	logic              exp_fb  [n_entries];
	logic              exp_conflict;

	logic [31:0]       lfsr_q = 32'h9d543517;
	int                cycle_cnt = 0;

	oflow_clk_gen #(
		.reset_cycles (5)
	) u_clk_gen (
		.clk     (clk),
		.reset_N (reset_N)
	);

	oflow_conflict_top #(
		.max_conflicts (max_conflicts)
	) uut (
		.clk         (clk),
		.reset_N     (reset_N),
		.start       (start),
		.done        (done),
		.busy        (busy),
		.conflict_th (conflict_th),
		.load_en     (load_en),
		.load_row    (load_row),
		.load_pe     (load_pe),
		.load_score  (load_score),
		.load_id     (load_id),
		.rd_row      (rd_row),
		.rd_pe       (rd_pe),
		.rd_fallback (rd_fallback)
	);

	// ------------------------------------------------------------------------
	// random numbers
	// ------------------------------------------------------------------------
	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// one LFSR step per bit taken
	task automatic draw_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_q = lfsr_next(lfsr_q);
			v = {v[30:0], lfsr_q[0]};
		end
	endtask

	// pairs share a table word and differ in the half bit
	function automatic oflow_pkg::id_t pool_id(input logic [2:0] k);
		case (k)
			3'd0:    return 7'h05;
			3'd1:    return 7'h45;
			3'd2:    return 7'h12;
			3'd3:    return 7'h52;
			3'd4:    return 7'h3f;
			3'd5:    return 7'h7f;
			3'd6:    return 7'h01;
			default: return 7'h23;
		endcase
	endfunction

	// ------------------------------------------------------------------------
	// failure reporting and compare tasks
	// ------------------------------------------------------------------------
	task automatic stop_on_error(input string what);
		$display("%s", what);
		$display("tests failed");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic check_fallback(input oflow_pkg::row_t row, input oflow_pkg::pe_t pe,
			input logic got, input logic expected);
		if (got !== expected)
			stop_on_error($sformatf("[FAIL] t=%0t rd_fallback[%0d][%0d] got %0b expected %0b",
				$time, row, pe, got, expected));
	endtask

	task automatic check_conflict(input logic got, input logic expected);
		if (got !== expected)
			stop_on_error($sformatf("[FAIL] t=%0t conflict_th got %0b expected %0b",
				$time, got, expected));
	endtask

	task automatic check_handshake(input string name, input logic got, input logic expected);
		if (got !== expected)
			stop_on_error($sformatf("[FAIL] t=%0t %s got %0b expected %0b",
				$time, name, got, expected));
	endtask

	// ------------------------------------------------------------------------
	// reference model
	// ------------------------------------------------------------------------
	// lowest score keeps the match and ties stay with the earlier entry
	task automatic run_model();
		int                cnt    [128];
		oflow_pkg::score_t min_s  [128];
		int                holder [128];
		int                c;
		for (int i = 0; i < 128; i++) begin
			cnt[i]    = 0;
			min_s[i]  = '0;
			holder[i] = 0;
		end
		exp_conflict = 1'b0;
		for (int e = 0; e < n_entries; e++) begin
			exp_fb[e] = 1'b0;
		end
		for (int e = 0; e < n_entries; e++) begin
			if (f_id[e] == '0)
				break;
			c = cnt[f_id[e]];
			if (c == 0) begin
				min_s[f_id[e]]  = f_score[e];
				holder[f_id[e]] = e;
			end else if (f_score[e] < min_s[f_id[e]]) begin
				exp_fb[holder[f_id[e]]] = 1'b1;
				min_s[f_id[e]]          = f_score[e];
				holder[f_id[e]]         = e;
			end else begin
				exp_fb[e] = 1'b1;
			end
			cnt[f_id[e]] = c + 1;
			// entry is resolved before the scan gives up
			if (c >= max_conflicts) begin
				exp_conflict = 1'b1;
				break;
			end
		end
	endtask

	// ------------------------------------------------------------------------
	// frame generators
	// ------------------------------------------------------------------------
	task automatic make_distinct();
		logic [31:0] v;
		for (int e = 0; e < n_entries; e++) begin
			draw_bits(8, v);
			f_score[e] = oflow_pkg::score_t'(v);
			f_id[e]    = oflow_pkg::id_t'(e * 7 + 3);
		end
	endtask

	task automatic make_random();
		logic [31:0] v;
		for (int e = 0; e < n_entries; e++) begin
			draw_bits(1, v);
			if (v[0]) begin
				// narrow range so equal scores show up
				draw_bits(3, v);
			end else begin
				draw_bits(8, v);
			end
			f_score[e] = oflow_pkg::score_t'(v);
			draw_bits(3, v);
			f_id[e] = pool_id(v[2:0]);
		end
	endtask

	task automatic make_zero();
		logic [31:0] v;
		make_random();
		draw_bits(4, v);
		f_id[v[3:0]] = '0;
	endtask

	// five copies of one id spaced three apart
	task automatic make_conflict();
		logic [31:0] v;
		int          r;
		make_random();
		draw_bits(2, v);
		r = int'(v[1:0]);
		for (int k = 0; k < 5; k++) begin
			f_id[r + 3 * k] = 7'h2a;
		end
	endtask

	// ------------------------------------------------------------------------
	// bus activity
	// ------------------------------------------------------------------------
	task automatic load_frame();
		for (int e = 0; e < n_entries; e++) begin
			@(negedge clk);
			load_en    = 1'b1;
			load_row   = oflow_pkg::row_t'(e / `OFLOW_PES);
			load_pe    = oflow_pkg::pe_t'(e % `OFLOW_PES);
			load_score = f_score[e];
			load_id    = f_id[e];
		end
		@(negedge clk);
		load_en = 1'b0;
	endtask

	task automatic read_all(input logic all_zero);
		for (int e = 0; e < n_entries; e++) begin
			rd_row = oflow_pkg::row_t'(e / `OFLOW_PES);
			rd_pe  = oflow_pkg::pe_t'(e % `OFLOW_PES);
			#1;
			check_fallback(rd_row, rd_pe, rd_fallback, all_zero ? 1'b0 : exp_fb[e]);
			@(negedge clk);
		end
	endtask

	// pulse start on a falling edge and wait for done
	task automatic run_frame();
		load_frame();
		run_model();
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		check_handshake("busy", busy, 1'b1);
		while (done !== 1'b1) begin
			@(negedge clk);
		end
		check_handshake("busy", busy, 1'b0);
		check_conflict(conflict_th, exp_conflict);
		@(negedge clk);
		check_handshake("done", done, 1'b0);
		read_all(1'b0);
		check_conflict(conflict_th, exp_conflict);
	endtask

	always @(posedge clk) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt > timeout_cycles)
			stop_on_error($sformatf("timeout after %0d cycles, a scan never finished",
				cycle_cnt));
	end

	// ------------------------------------------------------------------------
	// test sequence
	// ------------------------------------------------------------------------
	initial begin
		start      = 1'b0;
		load_en    = 1'b0;
		load_row   = '0;
		load_pe    = '0;
		load_score = '0;
		load_id    = '0;
		rd_row     = '0;
		rd_pe      = '0;

		@(posedge reset_N);
		@(negedge clk);

		// state straight out of reset
		check_handshake("done", done, 1'b0);
		check_handshake("busy", busy, 1'b0);
		check_conflict(conflict_th, 1'b0);
		read_all(1'b1);

		make_distinct();
		run_frame();

		// frames follow each other without reset
		for (int f = 0; f < n_random; f++) begin
			make_random();
			run_frame();
		end
		for (int f = 0; f < n_zero; f++) begin
			make_zero();
			run_frame();
		end
		for (int f = 0; f < n_conflict; f++) begin
			make_conflict();
			run_frame();
		end

		$display("all tests passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+hdl
hdl/oflow_pkg.sv
hdl/oflow_score_board.sv
hdl/oflow_id_lut.sv
hdl/oflow_conflict_resolve_fsm.sv
hdl/oflow_conflict_top.sv
tb/oflow_clk_gen.sv
tb/oflow_conflict_tb.sv

//--- Makefile
TOP = oflow_conflict_tb
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build folder and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -f filelist.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "all tests passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
